/* source/alu_ops_pkg.sv */
`default_nettype none

package alu_ops_pkg;

	localparam int data_width = 32;
	localparam int num_lanes = 4;
	localparam int lane_bits = $clog2(num_lanes);
	localparam int shamt_bits = $clog2(data_width); // shift amount comes from a[4:0]
	localparam int count_width = $clog2(data_width) + 1; // clo/clz can reach 32

	// mips encoding with unused codes at 15 and 23 up
	typedef enum logic [4:0] {
		op_add  = 5'd0,
		op_sub  = 5'd1,
		op_or   = 5'd2,
		op_and  = 5'd3,
		op_nor  = 5'd4,
		op_xor  = 5'd5,
		op_sll  = 5'd6,
		op_srl  = 5'd7,
		op_sra  = 5'd8,
		op_slt  = 5'd9,
		op_sltu = 5'd10,
		op_move = 5'd11, // movn/movz pass a through
		op_addu = 5'd12,
		op_clo  = 5'd13,
		op_clz  = 5'd14,
		op_subu = 5'd16,
		op_teq  = 5'd17,
		op_tge  = 5'd18,
		op_tgeu = 5'd19,
		op_tlt  = 5'd20,
		op_tltu = 5'd21,
		op_tne  = 5'd22
	} alu_op_e;

	typedef struct packed {
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		alu_op_e op;
	} alu_job_t;

	typedef struct packed {
		logic [data_width-1:0] c;
		logic overflow;
		logic trap;
	} alu_result_t;

endpackage

`default_nettype wire

/* source/apb_regs_pkg.sv */
`default_nettype none

package apb_regs_pkg;

	localparam int apb_addr_width = 8;
	localparam int apb_data_width = 32;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [apb_addr_width-1:0] paddr;
		logic [apb_data_width-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [apb_data_width-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	localparam logic [apb_addr_width-1:0] addr_opa = 8'h00;
	localparam logic [apb_addr_width-1:0] addr_opb = 8'h04;
	localparam logic [apb_addr_width-1:0] addr_cmd = 8'h08;
	localparam logic [apb_addr_width-1:0] addr_status = 8'h0C;
	localparam logic [apb_addr_width-1:0] addr_result_base = 8'h10; // lane n at base + 4n

	localparam int cmd_op_lsb = 0; // opcode in cmd[4:0]
	localparam int cmd_lane_lsb = 8; // lane in cmd[9:8]

	localparam int status_done_lsb = 0;
	localparam int status_ovf_lsb = 8;
	localparam int status_trap_lsb = 16;

endpackage

`default_nettype wire

/* source/alu_core.sv */
`default_nettype none

module alu_core (
	input  alu_ops_pkg::alu_job_t    job,
	output alu_ops_pkg::alu_result_t result
);

	logic [alu_ops_pkg::data_width-1:0] a;
	logic [alu_ops_pkg::data_width-1:0] b;
	logic [alu_ops_pkg::shamt_bits-1:0] shamt;
	logic [alu_ops_pkg::data_width-1:0] sum;
	logic [alu_ops_pkg::data_width-1:0] diff;
	logic [alu_ops_pkg::data_width-1:0] c_val;
	logic [alu_ops_pkg::count_width-1:0] clo_cnt;
	logic [alu_ops_pkg::count_width-1:0] clz_cnt;
	logic ones_run;
	logic zeros_run;
	logic lt_s;
	logic lt_u;
	logic eq;
	logic add_ovf;
	logic sub_ovf;
	logic ovf;
	logic trap_hit;

	assign a = job.a;
	assign b = job.b;
	assign shamt = a[alu_ops_pkg::shamt_bits-1:0];

	assign sum = a + b;
	assign diff = a - b;

	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;
	assign eq = a == b;

	// operands of equal sign and a result of the other sign
	assign add_ovf = (a[alu_ops_pkg::data_width-1] == b[alu_ops_pkg::data_width-1]) &&
		(sum[alu_ops_pkg::data_width-1] != a[alu_ops_pkg::data_width-1]);
	assign sub_ovf = (a[alu_ops_pkg::data_width-1] != b[alu_ops_pkg::data_width-1]) &&
		(diff[alu_ops_pkg::data_width-1] != a[alu_ops_pkg::data_width-1]);

	// leading ones and zeros counted from the msb down
	always_comb begin
		clo_cnt = '0;
		clz_cnt = '0;
		ones_run = 1'b1;
		zeros_run = 1'b1;
		for (int i = alu_ops_pkg::data_width - 1; i >= 0; i--) begin
			ones_run = ones_run & a[i];
			zeros_run = zeros_run & ~a[i];
			clo_cnt = clo_cnt + {{(alu_ops_pkg::count_width-1){1'b0}}, ones_run};
			clz_cnt = clz_cnt + {{(alu_ops_pkg::count_width-1){1'b0}}, zeros_run};
		end
	end

	always_comb begin
		case (job.op)
			alu_ops_pkg::op_teq:  trap_hit = eq;
			alu_ops_pkg::op_tge:  trap_hit = ~lt_s;
			alu_ops_pkg::op_tgeu: trap_hit = ~lt_u;
			alu_ops_pkg::op_tlt:  trap_hit = lt_s;
			alu_ops_pkg::op_tltu: trap_hit = lt_u;
			alu_ops_pkg::op_tne:  trap_hit = ~eq;
			default:              trap_hit = 1'b0;
		endcase
	end

	always_comb begin
		case (job.op)
			alu_ops_pkg::op_add:  ovf = add_ovf;
			alu_ops_pkg::op_sub:  ovf = sub_ovf;
			default:              ovf = 1'b0; // addu/subu never flag
		endcase
	end

	always_comb begin
		case (job.op)
			alu_ops_pkg::op_add,
			alu_ops_pkg::op_addu: c_val = sum;
			alu_ops_pkg::op_sub,
			alu_ops_pkg::op_subu: c_val = diff;
			alu_ops_pkg::op_or:   c_val = a | b;
			alu_ops_pkg::op_and:  c_val = a & b;
			alu_ops_pkg::op_nor:  c_val = ~(a | b);
			alu_ops_pkg::op_xor:  c_val = a ^ b;
			alu_ops_pkg::op_sll:  c_val = b << shamt;
			alu_ops_pkg::op_srl:  c_val = b >> shamt;
			alu_ops_pkg::op_sra:  c_val = $signed(b) >>> shamt;
			alu_ops_pkg::op_slt:  c_val = {{(alu_ops_pkg::data_width-1){1'b0}}, lt_s};
			alu_ops_pkg::op_sltu: c_val = {{(alu_ops_pkg::data_width-1){1'b0}}, lt_u};
			alu_ops_pkg::op_move: c_val = a;
			alu_ops_pkg::op_clo:
				c_val = {{(alu_ops_pkg::data_width-alu_ops_pkg::count_width){1'b0}}, clo_cnt};
			alu_ops_pkg::op_clz:
				c_val = {{(alu_ops_pkg::data_width-alu_ops_pkg::count_width){1'b0}}, clz_cnt};
			alu_ops_pkg::op_teq,
			alu_ops_pkg::op_tge,
			alu_ops_pkg::op_tgeu,
			alu_ops_pkg::op_tlt,
			alu_ops_pkg::op_tltu,
			alu_ops_pkg::op_tne:  c_val = {{(alu_ops_pkg::data_width-1){1'b0}}, trap_hit};
			default:              c_val = '0;
		endcase
	end

	assign result = '{c: c_val, overflow: ovf, trap: trap_hit};

endmodule

`default_nettype wire

/* source/alu_lane.sv */
`default_nettype none

module alu_lane (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     issue,
	input  alu_ops_pkg::alu_job_t    job,
	output alu_ops_pkg::alu_result_t result,
	output logic                     valid
);

	alu_ops_pkg::alu_result_t core_out;

	alu_core u_core (
		.job    (job),
		.result (core_out)
	);

	// result only means something while valid is up
	always_ff @(posedge clk) begin
		if (issue) begin
			result <= core_out;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= issue; // one cycle pulse per job
		end
	end

	// the collector stores whatever comes with valid
	a_valid_result_known: assert property (
		@(posedge clk) disable iff (rst)
		valid |-> !$isunknown(result)
	) else $error("lane result unknown while valid");

endmodule

`default_nettype wire

/* source/job_dispatcher.sv */
`default_nettype none

module job_dispatcher (
	input  logic                                                         clk,
	input  logic                                                         rst,
	input  apb_regs_pkg::apb_req_t                                       apb_req,
	output apb_regs_pkg::apb_rsp_t                                       apb_rsp,
	output alu_ops_pkg::alu_job_t                                        job,
	output logic [alu_ops_pkg::num_lanes-1:0]                            issue,
	input  logic [31:0]                                                  status,
	input  logic [alu_ops_pkg::num_lanes-1:0][alu_ops_pkg::data_width-1:0] results,
	output logic [alu_ops_pkg::num_lanes-1:0]                            read_clear
);

	logic [alu_ops_pkg::data_width-1:0] opa;
	logic [alu_ops_pkg::data_width-1:0] opb;
	logic wr;
	logic rd;
	logic is_result;
	logic [alu_ops_pkg::lane_bits-1:0] rd_lane;
	alu_ops_pkg::alu_op_e cmd_op;
	logic [alu_ops_pkg::lane_bits-1:0] cmd_lane;
	logic op_ok;
	logic wr_ok;
	logic rd_ok;
	logic cmd_fire;

	// transfer completes on the access cycle since pready is tied high
	assign wr = apb_req.psel & apb_req.penable & apb_req.pwrite;
	assign rd = apb_req.psel & apb_req.penable & ~apb_req.pwrite;

	assign is_result = (apb_req.paddr >= apb_regs_pkg::addr_result_base) &&
		(apb_req.paddr < apb_regs_pkg::addr_result_base + 8'(4 * alu_ops_pkg::num_lanes)) &&
		(apb_req.paddr[1:0] == 2'b00);
	assign rd_lane = apb_req.paddr[2 +: alu_ops_pkg::lane_bits];

	assign cmd_op = alu_ops_pkg::alu_op_e'(apb_req.pwdata[apb_regs_pkg::cmd_op_lsb +: 5]);
	assign cmd_lane = apb_req.pwdata[apb_regs_pkg::cmd_lane_lsb +: alu_ops_pkg::lane_bits];

	always_comb begin
		case (cmd_op)
			alu_ops_pkg::op_add, alu_ops_pkg::op_sub, alu_ops_pkg::op_or,
			alu_ops_pkg::op_and, alu_ops_pkg::op_nor, alu_ops_pkg::op_xor,
			alu_ops_pkg::op_sll, alu_ops_pkg::op_srl, alu_ops_pkg::op_sra,
			alu_ops_pkg::op_slt, alu_ops_pkg::op_sltu, alu_ops_pkg::op_move,
			alu_ops_pkg::op_addu, alu_ops_pkg::op_clo, alu_ops_pkg::op_clz,
			alu_ops_pkg::op_subu, alu_ops_pkg::op_teq, alu_ops_pkg::op_tge,
			alu_ops_pkg::op_tgeu, alu_ops_pkg::op_tlt, alu_ops_pkg::op_tltu,
			alu_ops_pkg::op_tne: op_ok = 1'b1;
			default:             op_ok = 1'b0;
		endcase
	end

	// status and results are read only and cmd is write only
	assign wr_ok = (apb_req.paddr == apb_regs_pkg::addr_opa) ||
		(apb_req.paddr == apb_regs_pkg::addr_opb) ||
		((apb_req.paddr == apb_regs_pkg::addr_cmd) && op_ok);
	assign rd_ok = (apb_req.paddr == apb_regs_pkg::addr_opa) ||
		(apb_req.paddr == apb_regs_pkg::addr_opb) ||
		(apb_req.paddr == apb_regs_pkg::addr_status) || is_result;

	assign cmd_fire = wr && (apb_req.paddr == apb_regs_pkg::addr_cmd) && op_ok;

	always_comb begin
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = (wr & ~wr_ok) | (rd & ~rd_ok);
		apb_rsp.prdata = '0;
		if (apb_req.paddr == apb_regs_pkg::addr_opa) apb_rsp.prdata = opa;
		else if (apb_req.paddr == apb_regs_pkg::addr_opb) apb_rsp.prdata = opb;
		else if (apb_req.paddr == apb_regs_pkg::addr_status) apb_rsp.prdata = status;
		else if (is_result) apb_rsp.prdata = results[rd_lane];
	end

	always_comb begin
		read_clear = '0;
		read_clear[rd_lane] = rd & is_result; // done drops on this access edge
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			opa <= '0;
			opb <= '0;
			issue <= '0;
		end else begin
			issue <= '0;
			if (wr && apb_req.paddr == apb_regs_pkg::addr_opa) opa <= apb_req.pwdata;
			if (wr && apb_req.paddr == apb_regs_pkg::addr_opb) opb <= apb_req.pwdata;
			if (cmd_fire) issue[cmd_lane] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			job <= '{a: opa, b: opb, op: cmd_op}; // shared bus and issue picks the lane
		end
	end

	a_issue_one_cycle: assert property (
		@(posedge clk) disable iff (rst) (issue != '0) |=> (issue == '0)
	) else $error("issue held for more than one cycle");

	a_no_issue_on_err: assert property (
		@(posedge clk) disable iff (rst) apb_rsp.pslverr |=> (issue == '0)
	) else $error("issue raised after an errored access");

endmodule

`default_nettype wire

/* source/result_collector.sv */
`default_nettype none

module result_collector (
	input  logic                                                           clk,
	input  logic                                                           rst,
	input  alu_ops_pkg::alu_result_t [alu_ops_pkg::num_lanes-1:0]          lane_result,
	input  logic [alu_ops_pkg::num_lanes-1:0]                              lane_valid,
	input  logic [alu_ops_pkg::num_lanes-1:0]                              read_clear,
	output logic [31:0]                                                    status,
	output logic [alu_ops_pkg::num_lanes-1:0][alu_ops_pkg::data_width-1:0] results
);

	alu_ops_pkg::alu_result_t [alu_ops_pkg::num_lanes-1:0] store_q;
	logic [alu_ops_pkg::num_lanes-1:0] done_q;
	logic [alu_ops_pkg::num_lanes-1:0] ovf;
	logic [alu_ops_pkg::num_lanes-1:0] trap;

	always_ff @(posedge clk) begin
		if (rst) begin
			store_q <= '0;
			done_q <= '0;
		end else begin
			for (int i = 0; i < alu_ops_pkg::num_lanes; i++) begin
				if (lane_valid[i]) begin
					store_q[i] <= lane_result[i]; // overwrites an unread result
					done_q[i] <= 1'b1;
				end else if (read_clear[i]) begin
					done_q[i] <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < alu_ops_pkg::num_lanes; i++) begin
			ovf[i] = store_q[i].overflow;
			trap[i] = store_q[i].trap;
			results[i] = store_q[i].c;
		end
	end

	always_comb begin
		status = '0;
		status[apb_regs_pkg::status_done_lsb +: alu_ops_pkg::num_lanes] = done_q;
		status[apb_regs_pkg::status_ovf_lsb +: alu_ops_pkg::num_lanes] = ovf;
		status[apb_regs_pkg::status_trap_lsb +: alu_ops_pkg::num_lanes] = trap;
	end

	// lanes are issued one at a time
	a_one_lane_valid: assert property (
		@(posedge clk) disable iff (rst) $onehot0(lane_valid)
	) else $error("more than one lane valid on the same edge");

endmodule

`default_nettype wire

/* source/mips_alu_array.sv */
`default_nettype none

module mips_alu_array (
	input  logic                   clk,
	input  logic                   rst,
	input  apb_regs_pkg::apb_req_t apb_req,
	output apb_regs_pkg::apb_rsp_t apb_rsp
);

	alu_ops_pkg::alu_job_t job;
	logic [alu_ops_pkg::num_lanes-1:0] issue;
	alu_ops_pkg::alu_result_t [alu_ops_pkg::num_lanes-1:0] lane_result;
	logic [alu_ops_pkg::num_lanes-1:0] lane_valid;
	logic [alu_ops_pkg::num_lanes-1:0] read_clear;
	logic [31:0] status;
	logic [alu_ops_pkg::num_lanes-1:0][alu_ops_pkg::data_width-1:0] results;

	job_dispatcher u_dispatcher (
		.clk        (clk),
		.rst        (rst),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.job        (job),
		.issue      (issue),
		.status     (status),
		.results    (results),
		.read_clear (read_clear)
	);

	for (genvar i = 0; i < alu_ops_pkg::num_lanes; i++) begin : g_lane
		alu_lane u_lane (
			.clk    (clk),
			.rst    (rst),
			.issue  (issue[i]),
			.job    (job),
			.result (lane_result[i]),
			.valid  (lane_valid[i])
		);
	end

	result_collector u_collector (
		.clk         (clk),
		.rst         (rst),
		.lane_result (lane_result),
		.lane_valid  (lane_valid),
		.read_clear  (read_clear),
		.status      (status),
		.results     (results)
	);

endmodule

`default_nettype wire

/* verification/alu_checker.sv */
`default_nettype none

module alu_checker (
	input logic                   clk,
	input logic                   rst,
	input apb_regs_pkg::apb_req_t apb_req,
	input apb_regs_pkg::apb_rsp_t apb_rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic valid;
		logic [1:0] lane;
		alu_ops_pkg::alu_result_t res;
	} pending_t;

	string test_name = "reset_state";
	int error_count = 0;
	int check_count = 0;
	logic [31:0] opa;
	logic [31:0] opb;
	alu_ops_pkg::alu_result_t store [4];
	logic [3:0] done;
	pending_t stage0; // job issued and not yet in the lane
	pending_t stage1; // lane output waiting for the collector

	function automatic alu_ops_pkg::alu_result_t model_alu(input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] op);
		alu_ops_pkg::alu_result_t r;
		logic [32:0] wide;
		logic [31:0] v;
		logic signed_lt;
		int n;
		r = '0;
		n = 0;
		v = a;
		signed_lt = (a[31] != b[31]) ? a[31] : (a < b); // negative side is less on mixed signs
		wide = '0;
		case (op)
			alu_ops_pkg::op_add, alu_ops_pkg::op_addu: begin
				wide = {a[31], a} + {b[31], b};
				r.c = wide[31:0];
				r.overflow = (op == alu_ops_pkg::op_add) && (wide[32] != wide[31]);
			end
			alu_ops_pkg::op_sub, alu_ops_pkg::op_subu: begin
				wide = {a[31], a} - {b[31], b};
				r.c = wide[31:0];
				r.overflow = (op == alu_ops_pkg::op_sub) && (wide[32] != wide[31]);
			end
			alu_ops_pkg::op_or:   r.c = a | b;
			alu_ops_pkg::op_and:  r.c = a & b;
			alu_ops_pkg::op_nor:  r.c = ~(a | b);
			alu_ops_pkg::op_xor:  r.c = a ^ b;
			alu_ops_pkg::op_sll:  r.c = b << a[4:0];
			alu_ops_pkg::op_srl:  r.c = b >> a[4:0];
			alu_ops_pkg::op_sra:  r.c = (b >> a[4:0]) | (b[31] ? ~(32'hffffffff >> a[4:0]) : 32'h0);
			alu_ops_pkg::op_slt:  r.c = {31'b0, signed_lt};
			alu_ops_pkg::op_sltu: r.c = {31'b0, a < b};
			alu_ops_pkg::op_move: r.c = a;
			alu_ops_pkg::op_clo: begin
				while (n < 32 && v[31]) begin
					v = v << 1;
					n++;
				end
				r.c = 32'(n);
			end
			alu_ops_pkg::op_clz: begin
				while (n < 32 && !v[31]) begin
					v = v << 1;
					n++;
				end
				r.c = 32'(n);
			end
			alu_ops_pkg::op_teq:  r.trap = (a == b);
			alu_ops_pkg::op_tge:  r.trap = !signed_lt;
			alu_ops_pkg::op_tgeu: r.trap = !(a < b);
			alu_ops_pkg::op_tlt:  r.trap = signed_lt;
			alu_ops_pkg::op_tltu: r.trap = (a < b);
			alu_ops_pkg::op_tne:  r.trap = (a != b);
			default:              r.c = '0;
		endcase
		if (r.trap) r.c = 32'd1; // trap compares also return the flag as the word
		return r;
	endfunction

	function automatic logic write_ok(input logic [7:0] addr, input logic [31:0] data);
		if (addr == apb_regs_pkg::addr_opa || addr == apb_regs_pkg::addr_opb) return 1'b1;
		if (addr == apb_regs_pkg::addr_cmd) return !(data[4:0] == 5'd15 || data[4:0] > 5'd22);
		return 1'b0;
	endfunction

	function automatic logic read_ok(input logic [7:0] addr);
		return addr == apb_regs_pkg::addr_opa || addr == apb_regs_pkg::addr_opb ||
			addr == apb_regs_pkg::addr_status ||
			(addr >= 8'h10 && addr <= 8'h1c && addr[1:0] == 2'b00);
	endfunction

	function automatic logic [31:0] model_status();
		logic [31:0] s;
		s = '0;
		for (int i = 0; i < 4; i++) begin
			s[apb_regs_pkg::status_done_lsb + i] = done[i];
			s[apb_regs_pkg::status_ovf_lsb + i] = store[i].overflow;
			s[apb_regs_pkg::status_trap_lsb + i] = store[i].trap;
		end
		return s;
	endfunction

	function automatic void compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("FAILED %s: %s expected %h, actual %h", test_name, what, expected, actual);
		end
	endfunction

	always @(posedge clk) begin
		pending_t issued;
		logic [3:0] clears;
		logic exp_err;
		logic [1:0] lane;
		issued = '0;
		clears = '0;
		lane = apb_req.paddr[3:2];
		if (rst) begin
			opa = '0;
			opb = '0;
			done = '0;
			stage0 = '0;
			stage1 = '0;
			for (int i = 0; i < 4; i++) store[i] = '0;
		end else begin
			if (apb_req.psel && apb_req.penable) begin
				exp_err = apb_req.pwrite ? !write_ok(apb_req.paddr, apb_req.pwdata) :
					!read_ok(apb_req.paddr);
				compare($sformatf("pslverr at %h", apb_req.paddr), 32'(exp_err),
					32'(apb_rsp.pslverr));
				if (!exp_err && apb_req.pwrite) begin
					if (apb_req.paddr == apb_regs_pkg::addr_opa) opa = apb_req.pwdata;
					else if (apb_req.paddr == apb_regs_pkg::addr_opb) opb = apb_req.pwdata;
					else issued = '{valid: 1'b1, lane: apb_req.pwdata[9:8],
						res: model_alu(opa, opb, apb_req.pwdata[4:0])};
				end else if (!exp_err) begin
					if (apb_req.paddr == apb_regs_pkg::addr_opa) compare("opa", opa, apb_rsp.prdata);
					else if (apb_req.paddr == apb_regs_pkg::addr_opb) compare("opb", opb, apb_rsp.prdata);
					else if (apb_req.paddr == apb_regs_pkg::addr_status)
						compare("status", model_status(), apb_rsp.prdata);
					else begin
						compare($sformatf("result lane %0d", lane), store[lane].c, apb_rsp.prdata);
						clears[lane] = 1'b1;
					end
				end
			end
			done = done & ~clears;
			if (stage1.valid) begin // a new result beats a clear on the same edge
				store[stage1.lane] = stage1.res;
				done[stage1.lane] = 1'b1;
			end
			stage1 = stage0;
			stage0 = issued;
		end
	end

endmodule

`default_nettype wire

/* verification/tb_mips_alu_array.sv */
`default_nettype none

module tb_mips_alu_array;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int wait_limit = 40;

	logic clk;
	logic rst;
	apb_regs_pkg::apb_req_t apb_req;
	apb_regs_pkg::apb_rsp_t apb_rsp;
	integer seed;
	int timeouts;
	logic [31:0] rd_data;

	mips_alu_array UUT (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	alu_checker u_checker (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic end_run();
		$display("checks: %0d, mismatches: %0d, timeouts: %0d", u_checker.check_count,
			u_checker.error_count, timeouts);
		if (u_checker.error_count == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata);
		int cycles;
		cycles = 0;
		@(posedge clk);
		#1;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		#1;
		while (!apb_rsp.pready && cycles < wait_limit) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!apb_rsp.pready) begin
			$display("timeout: APB slave never raised pready at address %h", addr);
			timeouts++;
		end
		rd_data = apb_rsp.prdata; // stable mid access cycle
		@(posedge clk);
		#1;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		apb_transfer(1'b1, addr, data);
	endtask

	task automatic apb_read(input logic [7:0] addr);
		apb_transfer(1'b0, addr, '0);
	endtask

	task automatic wait_done(input logic [3:0] lanes);
		int polls;
		polls = 0;
		apb_read(apb_regs_pkg::addr_status);
		while ((rd_data[apb_regs_pkg::status_done_lsb +: 4] & lanes) != lanes &&
			polls < wait_limit) begin
			apb_read(apb_regs_pkg::addr_status);
			polls++;
		end
		if ((rd_data[apb_regs_pkg::status_done_lsb +: 4] & lanes) != lanes) begin
			$display("timeout: done bits %b never came up in status", lanes);
			timeouts++;
		end
	endtask

	task automatic issue_job(input logic [31:0] a, input logic [31:0] b, input logic [4:0] op,
		input logic [1:0] lane);
		apb_write(apb_regs_pkg::addr_opa, a);
		apb_write(apb_regs_pkg::addr_opb, b);
		apb_write(apb_regs_pkg::addr_cmd, {22'b0, lane, 3'b0, op}); // lane 9:8, op 4:0
	endtask

	task automatic run_job(input logic [31:0] a, input logic [31:0] b, input logic [4:0] op,
		input logic [1:0] lane);
		issue_job(a, b, op, lane);
		wait_done(4'b0001 << lane);
		apb_read(apb_regs_pkg::addr_result_base + {4'b0, lane, 2'b00});
	endtask

	initial begin
		logic [4:0] basic_ops [$];
		logic [4:0] shift_ops [$];
		logic [4:0] ovf_ops [$];
		logic [4:0] cmp_ops [$];
		logic [31:0] a;
		logic [31:0] b;
		int idx;
		basic_ops = '{alu_ops_pkg::op_add, alu_ops_pkg::op_addu, alu_ops_pkg::op_sub,
			alu_ops_pkg::op_subu, alu_ops_pkg::op_or, alu_ops_pkg::op_and,
			alu_ops_pkg::op_nor, alu_ops_pkg::op_xor, alu_ops_pkg::op_move};
		shift_ops = '{alu_ops_pkg::op_sll, alu_ops_pkg::op_srl, alu_ops_pkg::op_sra};
		ovf_ops = '{alu_ops_pkg::op_add, alu_ops_pkg::op_sub, alu_ops_pkg::op_addu,
			alu_ops_pkg::op_subu, alu_ops_pkg::op_or, alu_ops_pkg::op_xor};
		cmp_ops = '{alu_ops_pkg::op_slt, alu_ops_pkg::op_sltu, alu_ops_pkg::op_teq,
			alu_ops_pkg::op_tge, alu_ops_pkg::op_tgeu, alu_ops_pkg::op_tlt,
			alu_ops_pkg::op_tltu, alu_ops_pkg::op_tne};
		seed = 32'h49c9a303;
		timeouts = 0;
		rd_data = '0;
		apb_req = '0;
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		apb_read(apb_regs_pkg::addr_status);
		apb_read(apb_regs_pkg::addr_opa);

		u_checker.test_name = "logic_arith";
		repeat (40) begin
			idx = $unsigned($random(seed)) % basic_ops.size();
			run_job($random(seed), $random(seed), basic_ops[idx], 2'($random(seed)));
		end

		u_checker.test_name = "shift_count";
		for (int i = 0; i < 24; i++) begin
			run_job($random(seed), $random(seed), shift_ops[i % 3], 2'(i));
		end
		run_job(32'h0, 32'h0, alu_ops_pkg::op_clz, 2'd0);
		run_job(32'h0, 32'h0, alu_ops_pkg::op_clo, 2'd1);
		run_job(32'hffffffff, 32'h0, alu_ops_pkg::op_clz, 2'd2);
		run_job(32'hffffffff, 32'h0, alu_ops_pkg::op_clo, 2'd3);
		for (int k = 0; k < 32; k++) begin // single set and single clear bits
			run_job(32'h1 << k, $random(seed), alu_ops_pkg::op_clz, 2'(k));
			run_job(32'h1 << k, $random(seed), alu_ops_pkg::op_clo, 2'(k + 1));
			run_job(~(32'h1 << k), $random(seed), alu_ops_pkg::op_clo, 2'(k + 2));
		end
		repeat (8) begin
			a = $random(seed);
			run_job(a, 32'h0, alu_ops_pkg::op_clo, 2'($random(seed)));
			run_job(a >> ($unsigned($random(seed)) % 32), 32'h0, alu_ops_pkg::op_clz, 2'd1);
		end

		u_checker.test_name = "overflow";
		for (int i = 0; i < 48; i++) begin
			a = (i % 2 == 0 ? 32'h7ffffff8 : 32'h80000000) + (32'($random(seed)) & 32'h7);
			b = (i % 4 < 2 ? 32'h00000004 : 32'hfffffffc) + (32'($random(seed)) & 32'h7);
			run_job(a, b, ovf_ops[i % 6], 2'($random(seed)));
		end

		u_checker.test_name = "compare_trap";
		for (int j = 0; j < 8; j++) begin
			a = $random(seed);
			b = $random(seed);
			run_job(a, a, cmp_ops[j], 2'(j));
			run_job(a | 32'h80000000, b & 32'h7fffffff, cmp_ops[j], 2'(j + 1));
			run_job(b & 32'h7fffffff, a | 32'h80000000, cmp_ops[j], 2'(j + 2));
			run_job(a, b, cmp_ops[j], 2'(j + 3));
		end

		u_checker.test_name = "all_lanes";
		for (int l = 0; l < 4; l++) begin
			issue_job($random(seed), $random(seed), basic_ops[l], 2'(l));
		end
		wait_done(4'b1111);
		for (int l = 0; l < 4; l++) begin // each read drops one done bit
			apb_read(apb_regs_pkg::addr_result_base + 8'(4 * l));
			apb_read(apb_regs_pkg::addr_status);
		end

		u_checker.test_name = "bus_errors";
		apb_read(8'h20);
		apb_write(8'h20, $random(seed));
		apb_read(8'h13);
		apb_write(8'hfc, $random(seed));
		apb_read(apb_regs_pkg::addr_cmd);
		apb_write(apb_regs_pkg::addr_opa, $random(seed));
		apb_write(apb_regs_pkg::addr_cmd, {22'b0, 2'd1, 3'b0, 5'd15});
		apb_write(apb_regs_pkg::addr_cmd, {22'b0, 2'd2, 3'b0, 5'd23});
		apb_write(apb_regs_pkg::addr_cmd, {22'b0, 2'd3, 3'b0, 5'd31});
		repeat (4) @(posedge clk);
		apb_read(apb_regs_pkg::addr_status); // no done bit may appear
		end_run();
	end

endmodule

`default_nettype wire

/* mips_alu_array.f */
source/alu_ops_pkg.sv
source/apb_regs_pkg.sv
source/alu_core.sv
source/alu_lane.sv
source/job_dispatcher.sv
source/result_collector.sv
source/mips_alu_array.sv
verification/alu_checker.sv
verification/tb_mips_alu_array.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_mips_alu_array
FILELIST ?= mips_alu_array.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= All checks passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
